// ==== include/mmio_consts.svh ====
`ifndef MMIO_CONSTS_SVH
`define MMIO_CONSTS_SVH

// bus widths of the manager port and of every target port
`define MMIO_ADDR_W 32
`define MMIO_DATA_W 32
`define MMIO_STRB_W (`MMIO_DATA_W / 8)

// the uart occupies two word addresses, everything else decodes to the sram
`define UART_BASE 32'h1000_0000
`define UART_STAT_ADDR (`UART_BASE + 32'h4)

// sram depth in 32-bit words, byte addresses at or above 4x this are errors
`define SRAM_WORDS 256

// clock cycles per serial bit and bytes held in the transmit buffer
`define UART_DIV 8
`define UART_FIFO_DEPTH 4

`endif

// ==== hw/mmio_pkg.sv ====
package mmio_pkg;

	// response code returned on the r and b channels
	typedef enum logic [1:0] {
		OKAY   = 2'b00,
		SLVERR = 2'b10
	} resp_e;

	// which target the crossbar is currently locked onto
	// ROUTE_IDLE means no transaction is in flight
	typedef enum logic [1:0] {
		ROUTE_IDLE = 2'd0,
		ROUTE_SRAM = 2'd1,
		ROUTE_UART = 2'd2
	} route_e;

endpackage

// ==== hw/uart_byte_fifo.sv ====
`include "mmio_consts.svh"

module uart_byte_fifo (
	input  logic       clk,
	input  logic       rst,
	input  logic       push,
	input  logic [7:0] push_data,
	output logic       full,
	input  logic       pop,
	output logic [7:0] pop_data,
	output logic       empty,
	output logic [2:0] count
);

	localparam int PTR_W = $clog2(`UART_FIFO_DEPTH);
	localparam logic [PTR_W-1:0] LAST = PTR_W'(`UART_FIFO_DEPTH - 1);

	logic [7:0] mem [`UART_FIFO_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic do_push;
	logic do_pop;

	// requests that would overflow or underflow are dropped here
	assign do_push = push && !full;
	assign do_pop = pop && !empty;

	assign full = (count == 3'(`UART_FIFO_DEPTH));
	assign empty = (count == 3'd0);
	// the head byte is visible before it is popped
	assign pop_data = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (do_push) begin
			mem[wr_ptr] <= push_data;
		end
	end

	// pointers wrap at the last slot, the count tracks occupancy
	always_ff @(posedge clk) begin
		if (!rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= 3'd0;
		end else begin
			if (do_push) begin
				wr_ptr <= (wr_ptr == LAST) ? '0 : wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= (rd_ptr == LAST) ? '0 : rd_ptr + 1'b1;
			end
			if (do_push && !do_pop) begin
				count <= count + 3'd1;
			end else if (do_pop && !do_push) begin
				count <= count - 3'd1;
			end
		end
	end

endmodule

// ==== hw/sram_slave.sv ====
`include "mmio_consts.svh"

module sram_slave (
	input  logic                    clk,
	input  logic                    rst,
	input  logic [`MMIO_ADDR_W-1:0] araddr,
	input  logic                    arvalid,
	output logic                    arready,
	output logic [`MMIO_DATA_W-1:0] rdata,
	output logic [1:0]              rresp,
	output logic                    rvalid,
	input  logic                    rready,
	input  logic [`MMIO_ADDR_W-1:0] awaddr,
	input  logic                    awvalid,
	output logic                    awready,
	input  logic [`MMIO_DATA_W-1:0] wdata,
	input  logic [`MMIO_STRB_W-1:0] wstrb,
	input  logic                    wvalid,
	output logic                    wready,
	output logic [1:0]              bresp,
	output logic                    bvalid,
	input  logic                    bready
);

	localparam int IDX_W = $clog2(`SRAM_WORDS);
	// first byte address past the end of the storage
	localparam logic [`MMIO_ADDR_W-1:0] ADDR_LIMIT = `MMIO_ADDR_W'(`SRAM_WORDS * 4);

	logic [`MMIO_DATA_W-1:0] mem [`SRAM_WORDS];
	mmio_pkg::resp_e rresp_q;
	mmio_pkg::resp_e bresp_q;
	logic [IDX_W-1:0] ar_idx;
	logic [IDX_W-1:0] aw_idx;
	logic rd_in_range;
	logic wr_in_range;
	logic rd_fire;
	logic wr_fire;

	// word index from the byte address, the two low bits are dropped
	assign ar_idx = araddr[IDX_W+1:2];
	assign aw_idx = awaddr[IDX_W+1:2];
	assign rd_in_range = (araddr < ADDR_LIMIT);
	assign wr_in_range = (awaddr < ADDR_LIMIT);

	// a pending response blocks the matching request channel
	assign arready = !rvalid;
	assign awready = !bvalid;
	assign wready = !bvalid;

	assign rd_fire = arvalid && arready;
	assign wr_fire = awvalid && awready && wvalid && wready;

	// byte lanes are written only where the strobe is set
	always_ff @(posedge clk) begin
		if (wr_fire && wr_in_range) begin
			for (int i = 0; i < `MMIO_STRB_W; i++) begin
				if (wstrb[i]) begin
					mem[aw_idx][8*i +: 8] <= wdata[8*i +: 8];
				end
			end
		end
	end

	// read data and response codes are captured with the request beat
	always_ff @(posedge clk) begin
		if (rd_fire) begin
			rdata <= rd_in_range ? mem[ar_idx] : '0;
			rresp_q <= rd_in_range ? mmio_pkg::OKAY : mmio_pkg::SLVERR;
		end
		if (wr_fire) begin
			bresp_q <= wr_in_range ? mmio_pkg::OKAY : mmio_pkg::SLVERR;
		end
	end

	// response valids rise one cycle after the request and hold until taken
	always_ff @(posedge clk) begin
		if (!rst) begin
			rvalid <= 1'b0;
			bvalid <= 1'b0;
		end else begin
			if (rd_fire) begin
				rvalid <= 1'b1;
			end else if (rready) begin
				rvalid <= 1'b0;
			end
			if (wr_fire) begin
				bvalid <= 1'b1;
			end else if (bready) begin
				bvalid <= 1'b0;
			end
		end
	end

	assign rresp = rresp_q;
	assign bresp = bresp_q;

endmodule

// ==== hw/uart_slave.sv ====
`include "mmio_consts.svh"

module uart_slave (
	input  logic                    clk,
	input  logic                    rst,
	input  logic [`MMIO_ADDR_W-1:0] araddr,
	input  logic                    arvalid,
	output logic                    arready,
	output logic [`MMIO_DATA_W-1:0] rdata,
	output logic [1:0]              rresp,
	output logic                    rvalid,
	input  logic                    rready,
	input  logic [`MMIO_ADDR_W-1:0] awaddr,
	input  logic                    awvalid,
	output logic                    awready,
	input  logic [`MMIO_DATA_W-1:0] wdata,
	input  logic [`MMIO_STRB_W-1:0] wstrb,
	input  logic                    wvalid,
	output logic                    wready,
	output logic [1:0]              bresp,
	output logic                    bvalid,
	input  logic                    bready,
	output logic                    tx
);

	localparam int DIV_W = $clog2(`UART_DIV);
	localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(`UART_DIV - 1);

	logic fifo_push;
	logic fifo_pop;
	logic fifo_full;
	logic fifo_empty;
	logic [7:0] fifo_head;
	logic [2:0] fifo_count;
	logic aw_is_data;
	logic wr_ready;
	logic wr_fire;
	logic rd_fire;
	logic [`MMIO_DATA_W-1:0] status;
	logic busy;
	logic [9:0] frame;
	logic [3:0] bit_cnt;
	logic [DIV_W-1:0] div_cnt;

	uart_byte_fifo u_fifo (
		.clk       (clk),
		.rst       (rst),
		.push      (fifo_push),
		.push_data (wdata[7:0]),
		.full      (fifo_full),
		.pop       (fifo_pop),
		.pop_data  (fifo_head),
		.empty     (fifo_empty),
		.count     (fifo_count)
	);

	// a data write stalls while the buffer is full, a status write never does
	assign aw_is_data = (awaddr == `UART_BASE);
	assign wr_ready = !bvalid && !(aw_is_data && fifo_full);
	assign awready = wr_ready;
	assign wready = wr_ready;
	assign wr_fire = awvalid && wvalid && wr_ready;

	// only the low byte lane carries a character
	assign fifo_push = wr_fire && aw_is_data && wstrb[0];

	// every access completes without error
	assign bresp = mmio_pkg::OKAY;
	assign rresp = mmio_pkg::OKAY;

	always_ff @(posedge clk) begin
		if (!rst) begin
			bvalid <= 1'b0;
		end else if (wr_fire) begin
			bvalid <= 1'b1;
		end else if (bready) begin
			bvalid <= 1'b0;
		end
	end

	// status word holds fill level in bits 2:0 and shifter busy in bit 3
	assign status = {{(`MMIO_DATA_W - 4){1'b0}}, busy, fifo_count};
	assign arready = !rvalid;
	assign rd_fire = arvalid && arready;

	always_ff @(posedge clk) begin
		if (rd_fire) begin
			rdata <= (araddr == `UART_STAT_ADDR) ? status : '0;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst) begin
			rvalid <= 1'b0;
		end else if (rd_fire) begin
			rvalid <= 1'b1;
		end else if (rready) begin
			rvalid <= 1'b0;
		end
	end

	// the shifter takes the next byte as soon as it goes idle
	assign fifo_pop = !busy && !fifo_empty;

	// frame is stop, eight data bits lsb first, then start in bit 0
	always_ff @(posedge clk) begin
		if (fifo_pop) begin
			frame <= {1'b1, fifo_head, 1'b0};
		end else if (busy && div_cnt == DIV_LAST) begin
			frame <= {1'b1, frame[9:1]};
		end
	end

	// ten bit periods per byte, the stop bit gets its full length
	always_ff @(posedge clk) begin
		if (!rst) begin
			busy <= 1'b0;
			bit_cnt <= 4'd0;
			div_cnt <= '0;
		end else if (fifo_pop) begin
			busy <= 1'b1;
			bit_cnt <= 4'd0;
			div_cnt <= '0;
		end else if (busy) begin
			if (div_cnt == DIV_LAST) begin
				div_cnt <= '0;
				if (bit_cnt == 4'd9) begin
					busy <= 1'b0;
				end else begin
					bit_cnt <= bit_cnt + 4'd1;
				end
			end else begin
				div_cnt <= div_cnt + 1'b1;
			end
		end
	end

	// line idles high between frames
	assign tx = busy ? frame[0] : 1'b1;

endmodule

// ==== hw/mmio_xbar.sv ====
`include "mmio_consts.svh"

module mmio_xbar (
	input  logic                    clk,
	input  logic                    rst,

	// manager side
	input  logic [`MMIO_ADDR_W-1:0] araddr,
	input  logic                    arvalid,
	output logic                    arready,
	output logic [`MMIO_DATA_W-1:0] rdata,
	output logic [1:0]              rresp,
	output logic                    rvalid,
	input  logic                    rready,
	input  logic [`MMIO_ADDR_W-1:0] awaddr,
	input  logic                    awvalid,
	output logic                    awready,
	input  logic [`MMIO_DATA_W-1:0] wdata,
	input  logic [`MMIO_STRB_W-1:0] wstrb,
	input  logic                    wvalid,
	output logic                    wready,
	output logic [1:0]              bresp,
	output logic                    bvalid,
	input  logic                    bready,

	// sram target
	output logic [`MMIO_ADDR_W-1:0] sram_araddr,
	output logic                    sram_arvalid,
	input  logic                    sram_arready,
	input  logic [`MMIO_DATA_W-1:0] sram_rdata,
	input  logic [1:0]              sram_rresp,
	input  logic                    sram_rvalid,
	output logic                    sram_rready,
	output logic [`MMIO_ADDR_W-1:0] sram_awaddr,
	output logic                    sram_awvalid,
	input  logic                    sram_awready,
	output logic [`MMIO_DATA_W-1:0] sram_wdata,
	output logic [`MMIO_STRB_W-1:0] sram_wstrb,
	output logic                    sram_wvalid,
	input  logic                    sram_wready,
	input  logic [1:0]              sram_bresp,
	input  logic                    sram_bvalid,
	output logic                    sram_bready,

	// uart target
	output logic [`MMIO_ADDR_W-1:0] uart_araddr,
	output logic                    uart_arvalid,
	input  logic                    uart_arready,
	input  logic [`MMIO_DATA_W-1:0] uart_rdata,
	input  logic [1:0]              uart_rresp,
	input  logic                    uart_rvalid,
	output logic                    uart_rready,
	output logic [`MMIO_ADDR_W-1:0] uart_awaddr,
	output logic                    uart_awvalid,
	input  logic                    uart_awready,
	output logic [`MMIO_DATA_W-1:0] uart_wdata,
	output logic [`MMIO_STRB_W-1:0] uart_wstrb,
	output logic                    uart_wvalid,
	input  logic                    uart_wready,
	input  logic [1:0]              uart_bresp,
	input  logic                    uart_bvalid,
	output logic                    uart_bready
);

	mmio_pkg::route_e state;
	// set when the locked transaction is a write, so the idle channel pair stays quiet
	logic wr_sel;
	logic sel_sram;
	logic sel_uart;
	logic rd_on;
	logic wr_on;

	// the uart owns exactly two word addresses
	function automatic logic hits_uart(input logic [`MMIO_ADDR_W-1:0] addr);
		hits_uart = (addr == `UART_BASE) || (addr == `UART_STAT_ADDR);
	endfunction

	// writes win over reads when both are pending in idle
	always_ff @(posedge clk) begin
		if (!rst) begin
			state <= mmio_pkg::ROUTE_IDLE;
			wr_sel <= 1'b0;
		end else begin
			case (state)
				mmio_pkg::ROUTE_IDLE: begin
					if (awvalid && wvalid) begin
						state <= hits_uart(awaddr) ? mmio_pkg::ROUTE_UART : mmio_pkg::ROUTE_SRAM;
						wr_sel <= 1'b1;
					end else if (arvalid) begin
						state <= hits_uart(araddr) ? mmio_pkg::ROUTE_UART : mmio_pkg::ROUTE_SRAM;
						wr_sel <= 1'b0;
					end
				end
				default: begin
					// release on the final response beat seen at the manager port
					if (wr_sel ? (bvalid && bready) : (rvalid && rready)) begin
						state <= mmio_pkg::ROUTE_IDLE;
					end
				end
			endcase
		end
	end

	// in idle both selects are low, which forces every output below to zero
	assign sel_sram = (state == mmio_pkg::ROUTE_SRAM);
	assign sel_uart = (state == mmio_pkg::ROUTE_UART);
	assign rd_on = !wr_sel;
	assign wr_on = wr_sel;

	// responses back to the manager, an and-or mux on the route only
	assign arready = rd_on && ((sel_sram && sram_arready) || (sel_uart && uart_arready));
	assign rdata = ({`MMIO_DATA_W{sel_sram}} & sram_rdata) | ({`MMIO_DATA_W{sel_uart}} & uart_rdata);
	assign rresp = ({2{sel_sram}} & sram_rresp) | ({2{sel_uart}} & uart_rresp);
	assign rvalid = rd_on && ((sel_sram && sram_rvalid) || (sel_uart && uart_rvalid));
	assign awready = wr_on && ((sel_sram && sram_awready) || (sel_uart && uart_awready));
	assign wready = wr_on && ((sel_sram && sram_wready) || (sel_uart && uart_wready));
	assign bresp = ({2{sel_sram}} & sram_bresp) | ({2{sel_uart}} & uart_bresp);
	assign bvalid = wr_on && ((sel_sram && sram_bvalid) || (sel_uart && uart_bvalid));

	// the sram only sees the request while it is the locked target
	assign sram_araddr = {`MMIO_ADDR_W{sel_sram}} & araddr;
	assign sram_arvalid = sel_sram && rd_on && arvalid;
	assign sram_rready = sel_sram && rd_on && rready;
	assign sram_awaddr = {`MMIO_ADDR_W{sel_sram}} & awaddr;
	assign sram_awvalid = sel_sram && wr_on && awvalid;
	assign sram_wdata = {`MMIO_DATA_W{sel_sram}} & wdata;
	assign sram_wstrb = {`MMIO_STRB_W{sel_sram}} & wstrb;
	assign sram_wvalid = sel_sram && wr_on && wvalid;
	assign sram_bready = sel_sram && wr_on && bready;

	// same steering towards the uart
	assign uart_araddr = {`MMIO_ADDR_W{sel_uart}} & araddr;
	assign uart_arvalid = sel_uart && rd_on && arvalid;
	assign uart_rready = sel_uart && rd_on && rready;
	assign uart_awaddr = {`MMIO_ADDR_W{sel_uart}} & awaddr;
	assign uart_awvalid = sel_uart && wr_on && awvalid;
	assign uart_wdata = {`MMIO_DATA_W{sel_uart}} & wdata;
	assign uart_wstrb = {`MMIO_STRB_W{sel_uart}} & wstrb;
	assign uart_wvalid = sel_uart && wr_on && wvalid;
	assign uart_bready = sel_uart && wr_on && bready;

endmodule

// ==== hw/mmio_top.sv ====
`include "mmio_consts.svh"

module mmio_top (
	input  logic                    clk,
	input  logic                    rst,
	output logic                    tx,
	input  logic [`MMIO_ADDR_W-1:0] araddr,
	input  logic                    arvalid,
	output logic                    arready,
	output logic [`MMIO_DATA_W-1:0] rdata,
	output logic [1:0]              rresp,
	output logic                    rvalid,
	input  logic                    rready,
	input  logic [`MMIO_ADDR_W-1:0] awaddr,
	input  logic                    awvalid,
	output logic                    awready,
	input  logic [`MMIO_DATA_W-1:0] wdata,
	input  logic [`MMIO_STRB_W-1:0] wstrb,
	input  logic                    wvalid,
	output logic                    wready,
	output logic [1:0]              bresp,
	output logic                    bvalid,
	input  logic                    bready
);

	// sram target channels
	logic [`MMIO_ADDR_W-1:0] sram_araddr;
	logic [`MMIO_ADDR_W-1:0] sram_awaddr;
	logic [`MMIO_DATA_W-1:0] sram_rdata;
	logic [`MMIO_DATA_W-1:0] sram_wdata;
	logic [`MMIO_STRB_W-1:0] sram_wstrb;
	logic [1:0] sram_rresp;
	logic [1:0] sram_bresp;
	logic sram_arvalid, sram_arready, sram_rvalid, sram_rready;
	logic sram_awvalid, sram_awready, sram_wvalid, sram_wready;
	logic sram_bvalid, sram_bready;

	// uart target channels
	logic [`MMIO_ADDR_W-1:0] uart_araddr;
	logic [`MMIO_ADDR_W-1:0] uart_awaddr;
	logic [`MMIO_DATA_W-1:0] uart_rdata;
	logic [`MMIO_DATA_W-1:0] uart_wdata;
	logic [`MMIO_STRB_W-1:0] uart_wstrb;
	logic [1:0] uart_rresp;
	logic [1:0] uart_bresp;
	logic uart_arvalid, uart_arready, uart_rvalid, uart_rready;
	logic uart_awvalid, uart_awready, uart_wvalid, uart_wready;
	logic uart_bvalid, uart_bready;

	// every crossbar port name matches a top port or a local net
	mmio_xbar u_xbar (.*);

	sram_slave u_sram (
		.clk     (clk),
		.rst     (rst),
		.araddr  (sram_araddr),
		.arvalid (sram_arvalid),
		.arready (sram_arready),
		.rdata   (sram_rdata),
		.rresp   (sram_rresp),
		.rvalid  (sram_rvalid),
		.rready  (sram_rready),
		.awaddr  (sram_awaddr),
		.awvalid (sram_awvalid),
		.awready (sram_awready),
		.wdata   (sram_wdata),
		.wstrb   (sram_wstrb),
		.wvalid  (sram_wvalid),
		.wready  (sram_wready),
		.bresp   (sram_bresp),
		.bvalid  (sram_bvalid),
		.bready  (sram_bready)
	);

	uart_slave u_uart (
		.clk     (clk),
		.rst     (rst),
		.araddr  (uart_araddr),
		.arvalid (uart_arvalid),
		.arready (uart_arready),
		.rdata   (uart_rdata),
		.rresp   (uart_rresp),
		.rvalid  (uart_rvalid),
		.rready  (uart_rready),
		.awaddr  (uart_awaddr),
		.awvalid (uart_awvalid),
		.awready (uart_awready),
		.wdata   (uart_wdata),
		.wstrb   (uart_wstrb),
		.wvalid  (uart_wvalid),
		.wready  (uart_wready),
		.bresp   (uart_bresp),
		.bvalid  (uart_bvalid),
		.bready  (uart_bready),
		.tx      (tx)
	);

endmodule

// ==== dv/mmio_tb.sv ====
`include "mmio_consts.svh"

module mmio_tb;

	// handshake waits must outlast a full frame of back-pressure from the uart
	localparam int HS_LIMIT = 40 * `UART_DIV;
	localparam int TX_LIMIT = 20 * `UART_DIV;

	logic clk;
	logic rst;
	logic tx;
	logic [`MMIO_ADDR_W-1:0] araddr;
	logic arvalid;
	logic arready;
	logic [`MMIO_DATA_W-1:0] rdata;
	logic [1:0] rresp;
	logic rvalid;
	logic rready;
	logic [`MMIO_ADDR_W-1:0] awaddr;
	logic awvalid;
	logic awready;
	logic [`MMIO_DATA_W-1:0] wdata;
	logic [`MMIO_STRB_W-1:0] wstrb;
	logic wvalid;
	logic wready;
	logic [1:0] bresp;
	logic bvalid;
	logic bready;

	// expected sram contents, indexed by word
	logic [`MMIO_DATA_W-1:0] model [`SRAM_WORDS];
	logic [`MMIO_ADDR_W-1:0] sram_addrs [5] = '{32'h0, 32'h4, 32'h20, 32'h100, 32'h3fc};

	mmio_top UUT (
		.clk     (clk),
		.rst     (rst),
		.tx      (tx),
		.araddr  (araddr),
		.arvalid (arvalid),
		.arready (arready),
		.rdata   (rdata),
		.rresp   (rresp),
		.rvalid  (rvalid),
		.rready  (rready),
		.awaddr  (awaddr),
		.awvalid (awvalid),
		.awready (awready),
		.wdata   (wdata),
		.wstrb   (wstrb),
		.wvalid  (wvalid),
		.wready  (wready),
		.bresp   (bresp),
		.bvalid  (bvalid),
		.bready  (bready)
	);

	always #5 clk = ~clk;

	task automatic check_eq(input logic [31:0] actual, input logic [31:0] expected,
		input string msg);
		if (actual !== expected) begin
			$display("Error at time %0t: %s, got %h, expected %h", $time, msg, actual, expected);
			$display("Result: FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic report_timeout(input string what);
		$display("Timeout at time %0t: gave up waiting for %s", $time, what);
		$display("Result: FAILED");
		$fatal(1, "wait timed out");
	endtask

	// ready is sampled at the falling edge, so the beat transfers on the next rising edge
	task automatic write_word(input logic [31:0] addr, input logic [31:0] data,
		input logic [3:0] strb, output logic [1:0] resp);
		int cycles;
		@(posedge clk);
		awaddr <= addr;
		wdata <= data;
		wstrb <= strb;
		awvalid <= 1'b1;
		wvalid <= 1'b1;
		bready <= 1'b1;
		cycles = 0;
		@(negedge clk);
		while (!(awready && wready)) begin
			cycles++;
			if (cycles > HS_LIMIT) report_timeout("aw and w handshake");
			@(negedge clk);
		end
		@(posedge clk);
		awvalid <= 1'b0;
		wvalid <= 1'b0;
		cycles = 0;
		@(negedge clk);
		while (!bvalid) begin
			cycles++;
			if (cycles > HS_LIMIT) report_timeout("write response");
			@(negedge clk);
		end
		resp = bresp;
		@(posedge clk);
		bready <= 1'b0;
	endtask

	task automatic read_word(input logic [31:0] addr, output logic [31:0] data,
		output logic [1:0] resp);
		int cycles;
		@(posedge clk);
		araddr <= addr;
		arvalid <= 1'b1;
		rready <= 1'b1;
		cycles = 0;
		@(negedge clk);
		while (!arready) begin
			cycles++;
			if (cycles > HS_LIMIT) report_timeout("ar handshake");
			@(negedge clk);
		end
		@(posedge clk);
		arvalid <= 1'b0;
		cycles = 0;
		@(negedge clk);
		while (!rvalid) begin
			cycles++;
			if (cycles > HS_LIMIT) report_timeout("read response");
			@(negedge clk);
		end
		data = rdata;
		resp = rresp;
		@(posedge clk);
		rready <= 1'b0;
	endtask

	// decodes one frame and returns once its stop bit has fully elapsed
	task automatic wait_tx_byte(output logic [7:0] data);
		int cycles;
		cycles = 0;
		@(negedge clk);
		while (tx !== 1'b0) begin
			cycles++;
			if (cycles > TX_LIMIT) report_timeout("a start bit on tx");
			@(negedge clk);
		end
		// first low sample is half a cycle into the start bit
		repeat (`UART_DIV / 2 - 1) @(negedge clk);
		check_eq(tx, 1'b0, "start bit in the middle of its period");
		for (int i = 0; i < 8; i++) begin
			repeat (`UART_DIV) @(negedge clk);
			data[i] = tx;
		end
		repeat (`UART_DIV) @(negedge clk);
		check_eq(tx, 1'b1, "stop bit");
		repeat (`UART_DIV / 2) @(negedge clk);
	endtask

	// byte lanes with a set strobe take the new data, the rest keep the old word
	function automatic logic [31:0] merge_strobed(input logic [31:0] old_word,
		input logic [31:0] new_word, input logic [3:0] strb);
		logic [31:0] merged;
		merged = old_word;
		for (int b = 0; b < 4; b++) begin
			if (strb[b]) merged[8*b +: 8] = new_word[8*b +: 8];
		end
		return merged;
	endfunction

	task automatic sram_write(input logic [31:0] addr, input logic [31:0] data,
		input logic [3:0] strb);
		logic [1:0] resp;
		write_word(addr, data, strb, resp);
		check_eq(resp, mmio_pkg::OKAY, "sram write response");
		model[addr >> 2] = merge_strobed(model[addr >> 2], data, strb);
	endtask

	task automatic sram_compare(input logic [31:0] addr);
		logic [31:0] data;
		logic [1:0] resp;
		read_word(addr, data, resp);
		check_eq(resp, mmio_pkg::OKAY, "sram read response");
		check_eq(data, model[addr >> 2], "sram read data against model");
	endtask

	task automatic idle_after_reset();
		logic [31:0] data;
		logic [1:0] resp;
		// nothing may answer before a request has been made
		repeat (4) begin
			@(negedge clk);
			check_eq(tx, 1'b1, "tx idle level after reset");
			check_eq(rvalid, 1'b0, "rvalid after reset");
			check_eq(bvalid, 1'b0, "bvalid after reset");
		end
		read_word(`UART_STAT_ADDR, data, resp);
		check_eq(resp, mmio_pkg::OKAY, "status read response after reset");
		check_eq(data, 32'h0, "uart status after reset");
	endtask

	task automatic random_readback();
		foreach (sram_addrs[i]) sram_write(sram_addrs[i], $urandom, 4'hf);
		foreach (sram_addrs[i]) sram_compare(sram_addrs[i]);
	endtask

	task automatic partial_strobe();
		sram_write(32'h4, $urandom, 4'b0101);
		sram_compare(32'h4);
		sram_write(32'h100, $urandom, 4'b1000);
		sram_compare(32'h100);
	endtask

	task automatic out_of_range();
		logic [31:0] data;
		logic [1:0] resp;
		// this address aliases word 0 if the range check were missing
		write_word(`SRAM_WORDS * 4, $urandom, 4'hf, resp);
		check_eq(resp, mmio_pkg::SLVERR, "out-of-range write response");
		read_word(`SRAM_WORDS * 4, data, resp);
		check_eq(resp, mmio_pkg::SLVERR, "out-of-range read response");
		check_eq(data, 32'h0, "out-of-range read data");
		sram_compare(32'h0);
	endtask

	// the monitor runs alongside the writes since the first frame starts at once
	task automatic send_and_monitor(input int n);
		logic [7:0] sent [$];
		logic [7:0] seen [$];
		logic [7:0] rx;
		logic [1:0] resp;
		for (int i = 0; i < n; i++) sent.push_back(8'($urandom));
		fork
			for (int i = 0; i < n; i++) begin
				write_word(`UART_BASE, {24'h0, sent[i]}, 4'h1, resp);
				check_eq(resp, mmio_pkg::OKAY, "uart data write response");
			end
			for (int i = 0; i < n; i++) begin
				wait_tx_byte(rx);
				seen.push_back(rx);
			end
		join
		for (int i = 0; i < n; i++) check_eq(seen[i], sent[i], "byte decoded from tx");
	endtask

	task automatic uart_backpressure();
		logic [31:0] data;
		logic [1:0] resp;
		// six bytes exceed the buffer plus the shifter, so the last write stalls
		send_and_monitor(6);
		read_word(`UART_STAT_ADDR, data, resp);
		check_eq(resp, mmio_pkg::OKAY, "status read response after frames");
		check_eq(data, 32'h0, "uart status after the last frame");
	endtask

	initial begin
		void'($urandom(32'h7a30));
		clk = 1'b0;
		rst = 1'b0;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wstrb = '0;
		wvalid = 1'b0;
		bready = 1'b0;
		repeat (4) @(posedge clk);
		rst <= 1'b1;
		idle_after_reset();
		random_readback();
		partial_strobe();
		out_of_range();
		send_and_monitor(3);
		uart_backpressure();
		$display("Result: PASSED");
		$finish;
	end

endmodule

// ==== filelist.f ====
+incdir+include
hw/mmio_pkg.sv
hw/uart_byte_fifo.sv
hw/sram_slave.sv
hw/uart_slave.sv
hw/mmio_xbar.sv
hw/mmio_top.sv
dv/mmio_tb.sv

// ==== Bender.yml ====
package:
  name: mmio_fabric

sources:
  - include_dirs:
      - include
    files:
      - hw/mmio_pkg.sv
      - hw/uart_byte_fifo.sv
      - hw/sram_slave.sv
      - hw/uart_slave.sv
      - hw/mmio_xbar.sv
      - hw/mmio_top.sv
      - target: test
        files:
          - dv/mmio_tb.sv
